// File: ex_pkg.sv
`default_nettype none

package ex_pkg;

    localparam int XLEN   = 32;
    localparam int GPR_AW = 5;

    // jal and the branch-and-link ops write here
    localparam logic [GPR_AW-1:0] LINK_REG = 5'd31;

    // hilo read select
    localparam logic HILO_SEL_LO = 1'b0;
    localparam logic HILO_SEL_HI = 1'b1;

    typedef enum logic [7:0] {
        ALUOP_NOP    = 8'h00,
        ALUOP_ADD    = 8'h01,
        ALUOP_ADDI   = 8'h02,
        ALUOP_ADDU   = 8'h03,
        ALUOP_ADDIU  = 8'h04,
        ALUOP_SUB    = 8'h05,
        ALUOP_SUBU   = 8'h06,
        ALUOP_SLT    = 8'h07,
        ALUOP_SLTI   = 8'h08,
        ALUOP_SLTU   = 8'h09,
        ALUOP_SLTIU  = 8'h0a,
        ALUOP_DIV    = 8'h0b,
        ALUOP_DIVU   = 8'h0c,
        ALUOP_MULT   = 8'h0d,
        ALUOP_MULTU  = 8'h0e,
        ALUOP_AND    = 8'h0f,
        ALUOP_ANDI   = 8'h10,
        ALUOP_LUI    = 8'h11,
        ALUOP_NOR    = 8'h12,
        ALUOP_OR     = 8'h13,
        ALUOP_ORI    = 8'h14,
        ALUOP_XOR    = 8'h15,
        ALUOP_XORI   = 8'h16,
        ALUOP_SLL    = 8'h17,
        ALUOP_SLLV   = 8'h18,
        ALUOP_SRA    = 8'h19,
        ALUOP_SRAV   = 8'h1a,
        ALUOP_SRL    = 8'h1b,
        ALUOP_SRLV   = 8'h1c,
        ALUOP_BGEZAL = 8'h21,
        ALUOP_BLTZAL = 8'h23,
        ALUOP_JAL    = 8'h25,
        ALUOP_MFHI   = 8'h28,
        ALUOP_MFLO   = 8'h29,
        ALUOP_MTHI   = 8'h2a,
        ALUOP_MTLO   = 8'h2b
    } aluop_t;

    // one 64-bit word, seen whole (products) or as hi/lo halves
    typedef union packed {
        logic [2*XLEN-1:0] word;
        struct packed {
            logic [XLEN-1:0] hi;
            logic [XLEN-1:0] lo;
        } half;
    } hilo_u;

endpackage

`default_nettype wire

// File: ex_alu.sv
`timescale 1ns/100ps
`default_nettype none

module ex_alu (
    input  wire ex_pkg::aluop_t      aluop_i,
    input  wire [ex_pkg::XLEN-1:0]   instr_i,
    input  wire [ex_pkg::XLEN-1:0]   rs_data_i,
    input  wire [ex_pkg::XLEN-1:0]   rt_data_i,
    input  wire [ex_pkg::XLEN-1:0]   pc_return_addr_i,
    input  wire [ex_pkg::XLEN-1:0]   hilo_fwd_i,
    output logic [ex_pkg::XLEN-1:0]  result_o,
    output logic                     ovf_o
);

    import ex_pkg::*;

    logic [XLEN-1:0] imm_sext;
    logic [XLEN-1:0] imm_zext;
    logic [XLEN-1:0] imm_upper;
    logic [4:0]      shamt;
    logic [4:0]      shamt_reg;
    logic [XLEN-1:0] sum_rt;
    logic [XLEN-1:0] sum_imm;
    logic [XLEN-1:0] diff_rt;

    assign imm_sext  = {{(XLEN-16){instr_i[15]}}, instr_i[15:0]};
    assign imm_zext  = {{(XLEN-16){1'b0}}, instr_i[15:0]};
    assign imm_upper = {instr_i[15:0], 16'h0000};
    assign shamt     = instr_i[10:6];
    assign shamt_reg = rs_data_i[4:0];

    // one adder per operand pair, shared by signed and unsigned forms
    assign sum_rt  = rs_data_i + rt_data_i;
    assign sum_imm = rs_data_i + imm_sext;
    assign diff_rt = rs_data_i - rt_data_i;

    always_comb begin
        case (aluop_i)
            ALUOP_ADD, ALUOP_ADDU:             result_o = sum_rt;
            ALUOP_ADDI, ALUOP_ADDIU:           result_o = sum_imm;
            ALUOP_SUB, ALUOP_SUBU:             result_o = diff_rt;
            ALUOP_SLT:   result_o = XLEN'($signed(rs_data_i) < $signed(rt_data_i));
            ALUOP_SLTI:  result_o = XLEN'($signed(rs_data_i) < $signed(imm_sext));
            ALUOP_SLTU:  result_o = XLEN'(rs_data_i < rt_data_i);
            // compares against the sign-extended immediate, unsigned
            ALUOP_SLTIU: result_o = XLEN'(rs_data_i < imm_sext);
            ALUOP_AND:   result_o = rs_data_i & rt_data_i;
            ALUOP_ANDI:  result_o = rs_data_i & imm_zext;
            ALUOP_OR:    result_o = rs_data_i | rt_data_i;
            ALUOP_ORI:   result_o = rs_data_i | imm_zext;
            ALUOP_XOR:   result_o = rs_data_i ^ rt_data_i;
            ALUOP_XORI:  result_o = rs_data_i ^ imm_zext;
            ALUOP_NOR:   result_o = ~(rs_data_i | rt_data_i);
            ALUOP_LUI:   result_o = imm_upper;
            ALUOP_SLL:   result_o = rt_data_i << shamt;
            ALUOP_SLLV:  result_o = rt_data_i << shamt_reg;
            ALUOP_SRL:   result_o = rt_data_i >> shamt;
            ALUOP_SRLV:  result_o = rt_data_i >> shamt_reg;
            ALUOP_SRA:   result_o = $signed(rt_data_i) >>> shamt;
            ALUOP_SRAV:  result_o = $signed(rt_data_i) >>> shamt_reg;
            ALUOP_JAL, ALUOP_BGEZAL, ALUOP_BLTZAL: result_o = pc_return_addr_i;
            ALUOP_MFHI, ALUOP_MFLO:            result_o = hilo_fwd_i;
            default:                           result_o = '0;
        endcase
    end

    // signed overflow, trapping forms only
    always_comb begin
        case (aluop_i)
            ALUOP_ADD:  ovf_o = (rs_data_i[XLEN-1] == rt_data_i[XLEN-1]) &&
                                (sum_rt[XLEN-1] != rs_data_i[XLEN-1]);
            ALUOP_ADDI: ovf_o = (rs_data_i[XLEN-1] == imm_sext[XLEN-1]) &&
                                (sum_imm[XLEN-1] != rs_data_i[XLEN-1]);
            ALUOP_SUB:  ovf_o = (rs_data_i[XLEN-1] != rt_data_i[XLEN-1]) &&
                                (diff_rt[XLEN-1] != rs_data_i[XLEN-1]);
            default:    ovf_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: ex_hilo_unit.sv
`timescale 1ns/100ps
`default_nettype none

module ex_hilo_unit (
    input  wire ex_pkg::aluop_t      aluop_i,
    input  wire [ex_pkg::XLEN-1:0]   rs_data_i,
    input  wire [ex_pkg::XLEN-1:0]   rt_data_i,
    input  wire [ex_pkg::XLEN-1:0]   hilo_data_i,
    input  wire                      hilo_sel_i,
    input  wire                      mem_hi_we_i,
    input  wire [ex_pkg::XLEN-1:0]   mem_hi_data_i,
    input  wire                      mem_lo_we_i,
    input  wire [ex_pkg::XLEN-1:0]   mem_lo_data_i,
    input  wire                      wb_hi_we_i,
    input  wire [ex_pkg::XLEN-1:0]   wb_hi_data_i,
    input  wire                      wb_lo_we_i,
    input  wire [ex_pkg::XLEN-1:0]   wb_lo_data_i,
    output logic [ex_pkg::XLEN-1:0]  hilo_fwd_o,
    output ex_pkg::hilo_u            hilo_wr_o
);

    import ex_pkg::*;

    logic                   mul_signed;
    logic signed [XLEN:0]   mul_a;
    logic signed [XLEN:0]   mul_b;
    logic [2*XLEN-1:0]      mul_prod;

    // mem is newer than wb, so it wins
    always_comb begin
        hilo_fwd_o = hilo_data_i;
        if (hilo_sel_i == HILO_SEL_HI) begin
            if (mem_hi_we_i) begin
                hilo_fwd_o = mem_hi_data_i;
            end else if (wb_hi_we_i) begin
                hilo_fwd_o = wb_hi_data_i;
            end
        end else begin
            if (mem_lo_we_i) begin
                hilo_fwd_o = mem_lo_data_i;
            end else if (wb_lo_we_i) begin
                hilo_fwd_o = wb_lo_data_i;
            end
        end
    end

    // one 33x33 signed multiplier serves both mult and multu
    assign mul_signed = (aluop_i == ALUOP_MULT);
    assign mul_a      = {mul_signed & rs_data_i[XLEN-1], rs_data_i};
    assign mul_b      = {mul_signed & rt_data_i[XLEN-1], rt_data_i};
    assign mul_prod   = mul_a * mul_b;

    always_comb begin
        hilo_wr_o.word = '0;
        case (aluop_i)
            ALUOP_MTHI, ALUOP_MTLO: begin
                hilo_wr_o.half.hi = rs_data_i;
                hilo_wr_o.half.lo = rs_data_i;
            end
            ALUOP_MULT, ALUOP_MULTU: begin
                hilo_wr_o.word = mul_prod;
            end
            default: begin
                hilo_wr_o.word = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: ex_divider.sv
`timescale 1ns/100ps
`default_nettype none

module ex_divider #(
    parameter int DIV_W = 32
) (
    input  wire                clk_i,
    input  wire                rst_n_i,
    input  wire                start_i,
    input  wire                signed_i,
    input  wire [DIV_W-1:0]    dividend_i,
    input  wire [DIV_W-1:0]    divisor_i,
    output logic [DIV_W-1:0]   quot_o,
    output logic [DIV_W-1:0]   rem_o,
    output logic               done_o
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_RUN  = 2'd1;
    localparam logic [1:0] ST_DONE = 2'd2;
    localparam int CNT_W = (DIV_W > 1) ? $clog2(DIV_W) : 1;

    logic [1:0]       state_q;
    logic [CNT_W-1:0] cnt_q;
    logic             load;
    logic             dvd_neg;
    logic             dvs_neg;
    logic [DIV_W-1:0] dvd_abs;
    logic [DIV_W-1:0] dvs_abs;
    logic [DIV_W-1:0] dvd_q;
    logic [DIV_W-1:0] dvs_q;
    logic [DIV_W-1:0] rem_q;
    logic             neg_quot_q;
    logic             neg_rem_q;
    logic [DIV_W:0]   shifted;
    logic [DIV_W:0]   trial;

    assign load    = (state_q == ST_IDLE) && start_i;
    assign dvd_neg = signed_i & dividend_i[DIV_W-1];
    assign dvs_neg = signed_i & divisor_i[DIV_W-1];
    assign dvd_abs = dvd_neg ? -dividend_i : dividend_i;
    assign dvs_abs = dvs_neg ? -divisor_i : divisor_i;

    // partial remainder stays below 2*divisor, so a set msb means no subtract
    assign shifted = {rem_q, dvd_q[DIV_W-1]};
    assign trial   = shifted - {1'b0, dvs_q};

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (start_i) begin
                        state_q <= ST_RUN;
                        cnt_q   <= CNT_W'(DIV_W - 1);
                    end
                end
                ST_RUN: begin
                    if (cnt_q == '0) begin
                        state_q <= ST_DONE;
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // dividend register doubles as the quotient shift register
    always_ff @(posedge clk_i) begin
        if (load) begin
            dvd_q      <= dvd_abs;
            dvs_q      <= dvs_abs;
            rem_q      <= '0;
            neg_quot_q <= dvd_neg ^ dvs_neg;
            neg_rem_q  <= dvd_neg;
        end else if (state_q == ST_RUN) begin
            if (!trial[DIV_W]) begin
                rem_q <= trial[DIV_W-1:0];
                dvd_q <= {dvd_q[DIV_W-2:0], 1'b1};
            end else begin
                rem_q <= shifted[DIV_W-1:0];
                dvd_q <= {dvd_q[DIV_W-2:0], 1'b0};
            end
        end
    end

    assign quot_o = neg_quot_q ? -dvd_q : dvd_q;
    assign rem_o  = neg_rem_q ? -rem_q : rem_q;
    assign done_o = (state_q == ST_DONE);

endmodule

`default_nettype wire

// File: ex_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module ex_ctrl (
    input  wire                        clk_i,
    input  wire                        rst_n_i,
    input  wire ex_pkg::aluop_t        aluop_i,
    input  wire [ex_pkg::XLEN-1:0]     instr_i,
    input  wire                        reg_we_i,
    input  wire [ex_pkg::GPR_AW-1:0]   reg_waddr_i,
    input  wire                        hi_we_i,
    input  wire                        lo_we_i,
    input  wire [ex_pkg::XLEN-1:0]     alu_result_i,
    input  wire                        alu_ovf_i,
    input  wire ex_pkg::hilo_u         hilo_wr_i,
    input  wire                        div_done_i,
    input  wire [ex_pkg::XLEN-1:0]     div_quot_i,
    input  wire [ex_pkg::XLEN-1:0]     div_rem_i,
    output logic                       div_start_o,
    output logic                       div_signed_o,
    output logic [ex_pkg::XLEN-1:0]    alu_data_o,
    output logic                       reg_we_o,
    output logic [ex_pkg::GPR_AW-1:0]  reg_waddr_o,
    output logic                       hi_we_o,
    output logic                       lo_we_o,
    output logic [ex_pkg::XLEN-1:0]    hi_data_o,
    output logic [ex_pkg::XLEN-1:0]    lo_data_o,
    output logic                       overflow_o,
    output logic                       stall_req_o
);

    import ex_pkg::*;

    logic              is_div;
    logic              is_link;
    logic [GPR_AW-1:0] waddr_next;
    hilo_u             div_word;
    hilo_u             hilo_next;

    assign is_div  = (aluop_i == ALUOP_DIV) || (aluop_i == ALUOP_DIVU);
    assign is_link = (aluop_i == ALUOP_JAL) || (aluop_i == ALUOP_BGEZAL) ||
                     (aluop_i == ALUOP_BLTZAL);

    // divider ignores start unless idle
    assign div_start_o  = is_div;
    assign div_signed_o = (aluop_i == ALUOP_DIV);

    // hold the stage until the divider's done cycle
    assign stall_req_o = is_div & ~div_done_i;

    // overflow turns the write into a write of $zero
    always_comb begin
        if (alu_ovf_i) begin
            waddr_next = '0;
        end else if (is_link) begin
            waddr_next = LINK_REG;
        end else begin
            waddr_next = reg_waddr_i;
        end
    end

    always_comb begin
        div_word.half.hi = div_rem_i;
        div_word.half.lo = div_quot_i;
    end

    assign hilo_next = is_div ? div_word : hilo_wr_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            alu_data_o  <= '0;
            reg_we_o    <= 1'b0;
            reg_waddr_o <= '0;
            hi_we_o     <= 1'b0;
            lo_we_o     <= 1'b0;
            hi_data_o   <= '0;
            lo_data_o   <= '0;
            overflow_o  <= 1'b0;
        end else begin
            alu_data_o  <= alu_result_i;
            reg_waddr_o <= waddr_next;
            hi_data_o   <= hilo_next.half.hi;
            lo_data_o   <= hilo_next.half.lo;
            if (stall_req_o) begin
                // bubble
                reg_we_o   <= 1'b0;
                hi_we_o    <= 1'b0;
                lo_we_o    <= 1'b0;
                overflow_o <= 1'b0;
            end else begin
                reg_we_o   <= reg_we_i;
                hi_we_o    <= hi_we_i;
                lo_we_o    <= lo_we_i;
                overflow_o <= alu_ovf_i;
            end
        end
    end

endmodule

`default_nettype wire

// File: ex_stage.sv
`timescale 1ns/100ps
`default_nettype none

module ex_stage (
    input  wire                        clk_i,
    input  wire                        rst_n_i,
    input  wire ex_pkg::aluop_t        aluop_i,
    input  wire [ex_pkg::XLEN-1:0]     instr_i,
    input  wire [ex_pkg::XLEN-1:0]     rs_data_i,
    input  wire [ex_pkg::XLEN-1:0]     rt_data_i,
    input  wire [ex_pkg::XLEN-1:0]     pc_return_addr_i,
    input  wire                        reg_we_i,
    input  wire [ex_pkg::GPR_AW-1:0]   reg_waddr_i,
    input  wire                        hi_we_i,
    input  wire                        lo_we_i,
    input  wire [ex_pkg::XLEN-1:0]     hilo_data_i,
    input  wire                        hilo_sel_i,
    input  wire                        mem_hi_we_i,
    input  wire [ex_pkg::XLEN-1:0]     mem_hi_data_i,
    input  wire                        mem_lo_we_i,
    input  wire [ex_pkg::XLEN-1:0]     mem_lo_data_i,
    input  wire                        wb_hi_we_i,
    input  wire [ex_pkg::XLEN-1:0]     wb_hi_data_i,
    input  wire                        wb_lo_we_i,
    input  wire [ex_pkg::XLEN-1:0]     wb_lo_data_i,
    output logic [ex_pkg::XLEN-1:0]    alu_data_o,
    output logic                       reg_we_o,
    output logic [ex_pkg::GPR_AW-1:0]  reg_waddr_o,
    output logic                       hi_we_o,
    output logic                       lo_we_o,
    output logic [ex_pkg::XLEN-1:0]    hi_data_o,
    output logic [ex_pkg::XLEN-1:0]    lo_data_o,
    output logic                       overflow_o,
    output logic                       stall_req_o
);

    import ex_pkg::*;

    logic            div_start;
    logic            div_signed;
    logic            div_done;
    logic [XLEN-1:0] div_quot;
    logic [XLEN-1:0] div_rem;
    logic [XLEN-1:0] alu_result;
    logic            alu_ovf;
    logic [XLEN-1:0] hilo_fwd;
    hilo_u           hilo_wr;

    ex_ctrl u_ctrl (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .aluop_i      (aluop_i),
        .instr_i      (instr_i),
        .reg_we_i     (reg_we_i),
        .reg_waddr_i  (reg_waddr_i),
        .hi_we_i      (hi_we_i),
        .lo_we_i      (lo_we_i),
        .alu_result_i (alu_result),
        .alu_ovf_i    (alu_ovf),
        .hilo_wr_i    (hilo_wr),
        .div_done_i   (div_done),
        .div_quot_i   (div_quot),
        .div_rem_i    (div_rem),
        .div_start_o  (div_start),
        .div_signed_o (div_signed),
        .alu_data_o   (alu_data_o),
        .reg_we_o     (reg_we_o),
        .reg_waddr_o  (reg_waddr_o),
        .hi_we_o      (hi_we_o),
        .lo_we_o      (lo_we_o),
        .hi_data_o    (hi_data_o),
        .lo_data_o    (lo_data_o),
        .overflow_o   (overflow_o),
        .stall_req_o  (stall_req_o)
    );

    ex_alu u_alu (
        .aluop_i          (aluop_i),
        .instr_i          (instr_i),
        .rs_data_i        (rs_data_i),
        .rt_data_i        (rt_data_i),
        .pc_return_addr_i (pc_return_addr_i),
        .hilo_fwd_i       (hilo_fwd),
        .result_o         (alu_result),
        .ovf_o            (alu_ovf)
    );

    ex_hilo_unit u_hilo (
        .aluop_i       (aluop_i),
        .rs_data_i     (rs_data_i),
        .rt_data_i     (rt_data_i),
        .hilo_data_i   (hilo_data_i),
        .hilo_sel_i    (hilo_sel_i),
        .mem_hi_we_i   (mem_hi_we_i),
        .mem_hi_data_i (mem_hi_data_i),
        .mem_lo_we_i   (mem_lo_we_i),
        .mem_lo_data_i (mem_lo_data_i),
        .wb_hi_we_i    (wb_hi_we_i),
        .wb_hi_data_i  (wb_hi_data_i),
        .wb_lo_we_i    (wb_lo_we_i),
        .wb_lo_data_i  (wb_lo_data_i),
        .hilo_fwd_o    (hilo_fwd),
        .hilo_wr_o     (hilo_wr)
    );

    // rs / rt
    ex_divider #(
        .DIV_W (XLEN)
    ) u_div (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .start_i    (div_start),
        .signed_i   (div_signed),
        .dividend_i (rs_data_i),
        .divisor_i  (rt_data_i),
        .quot_o     (div_quot),
        .rem_o      (div_rem),
        .done_o     (div_done)
    );

endmodule

`default_nettype wire

// File: tb_ex_model.svh
`ifndef TB_EX_MODEL_SVH
`define TB_EX_MODEL_SVH

// ops whose result goes to hi/lo instead of the register file
function automatic logic writes_hilo(input aluop_t op);
    return (op == ALUOP_MTHI) || (op == ALUOP_MTLO) || (op == ALUOP_MULT) ||
           (op == ALUOP_MULTU) || (op == ALUOP_DIV) || (op == ALUOP_DIVU);
endfunction

function automatic logic is_divide(input aluop_t op);
    return (op == ALUOP_DIV) || (op == ALUOP_DIVU);
endfunction

// exact sum in 64 bits, overflow when it does not fit a signed word
function automatic logic model_ovf(input aluop_t op, input logic [31:0] instr,
                                   input logic [31:0] rs, input logic [31:0] rt);
    longint s;
    case (op)
        ALUOP_ADD:  s = longint'($signed(rs)) + longint'($signed(rt));
        ALUOP_ADDI: s = longint'($signed(rs)) + longint'($signed(instr[15:0]));
        ALUOP_SUB:  s = longint'($signed(rs)) - longint'($signed(rt));
        default:    s = 64'd0;
    endcase
    return s != longint'($signed(s[31:0]));
endfunction

function automatic logic [31:0] model_fwd(input logic sel, input logic [31:0] reg_val,
                                          input logic mem_hi_we, input logic [31:0] mem_hi,
                                          input logic mem_lo_we, input logic [31:0] mem_lo,
                                          input logic wb_hi_we, input logic [31:0] wb_hi,
                                          input logic wb_lo_we, input logic [31:0] wb_lo);
    if (sel == HILO_SEL_HI) begin
        return mem_hi_we ? mem_hi : (wb_hi_we ? wb_hi : reg_val);
    end
    return mem_lo_we ? mem_lo : (wb_lo_we ? wb_lo : reg_val);
endfunction

function automatic logic [31:0] model_result(input aluop_t op, input logic [31:0] instr,
                                             input logic [31:0] rs, input logic [31:0] rt,
                                             input logic [31:0] pc, input logic [31:0] fwd);
    logic [31:0] simm;
    logic [31:0] zimm;
    logic [4:0]  sa;
    logic [4:0]  sv;
    logic [31:0] fill;
    simm = {{16{instr[15]}}, instr[15:0]};
    zimm = {16'h0000, instr[15:0]};
    sa   = instr[10:6];
    sv   = rs[4:0];
    // sign bits that an arithmetic right shift pulls in
    fill = rt[31] ? 32'hffff_ffff : 32'h0000_0000;
    case (op)
        ALUOP_ADD, ALUOP_ADDU:   return rs + rt;
        ALUOP_ADDI, ALUOP_ADDIU: return rs + simm;
        ALUOP_SUB, ALUOP_SUBU:   return rs - rt;
        ALUOP_SLT:   return {31'b0, longint'($signed(rs)) < longint'($signed(rt))};
        ALUOP_SLTI:  return {31'b0, longint'($signed(rs)) < longint'($signed(simm))};
        ALUOP_SLTU:  return {31'b0, {32'b0, rs} < {32'b0, rt}};
        ALUOP_SLTIU: return {31'b0, {32'b0, rs} < {32'b0, simm}};
        ALUOP_AND:   return rs & rt;
        ALUOP_ANDI:  return rs & zimm;
        ALUOP_OR:    return rs | rt;
        ALUOP_ORI:   return rs | zimm;
        ALUOP_XOR:   return rs ^ rt;
        ALUOP_XORI:  return rs ^ zimm;
        ALUOP_NOR:   return ~(rs | rt);
        ALUOP_LUI:   return {instr[15:0], 16'h0000};
        ALUOP_SLL:   return rt << sa;
        ALUOP_SLLV:  return rt << sv;
        ALUOP_SRL:   return rt >> sa;
        ALUOP_SRLV:  return rt >> sv;
        ALUOP_SRA:   return (rt >> sa) | (fill & ~(32'hffff_ffff >> sa));
        ALUOP_SRAV:  return (rt >> sv) | (fill & ~(32'hffff_ffff >> sv));
        ALUOP_JAL, ALUOP_BGEZAL, ALUOP_BLTZAL: return pc;
        ALUOP_MFHI, ALUOP_MFLO: return fwd;
        default:     return 32'h0000_0000;
    endcase
endfunction

function automatic logic [4:0] model_waddr(input aluop_t op, input logic [4:0] waddr,
                                           input logic ovf);
    if (ovf) begin
        return 5'd0;
    end
    if ((op == ALUOP_JAL) || (op == ALUOP_BGEZAL) || (op == ALUOP_BLTZAL)) begin
        return LINK_REG;
    end
    return waddr;
endfunction

// {hi, lo}
function automatic logic [63:0] model_hilo(input aluop_t op, input logic [31:0] rs,
                                           input logic [31:0] rt);
    longint sq;
    longint sr;
    sq = longint'($signed(rs)) / longint'($signed(rt));
    sr = longint'($signed(rs)) % longint'($signed(rt));
    case (op)
        ALUOP_MTHI, ALUOP_MTLO: return {rs, rs};
        ALUOP_MULT:  return longint'($signed(rs)) * longint'($signed(rt));
        ALUOP_MULTU: return {32'b0, rs} * {32'b0, rt};
        ALUOP_DIV:   return {sr[31:0], sq[31:0]};
        ALUOP_DIVU:  return {rs % rt, rs / rt};
        default:     return 64'd0;
    endcase
endfunction

`endif

// File: tb_ex_stage.sv
`timescale 1ns/100ps
`default_nettype none

module tb_ex_stage;

    import ex_pkg::*;

    `include "tb_ex_model.svh"

    localparam int CLK_PERIOD  = 100;
    localparam int RST_CYCLES  = 5;
    localparam int NUM_RUNS    = 600;
    localparam int NUM_OPS     = 35;
    localparam int STALL_LIMIT = XLEN + 4;

    integer seed;
    int     errors;
    int     checks;
    int     run;
    int     idx;
    logic   timed_out;

    aluop_t op_table [0:NUM_OPS-1];

    logic              clk_i;
    logic              rst_n_i;
    aluop_t            aluop_i;
    logic [XLEN-1:0]   instr_i;
    logic [XLEN-1:0]   rs_data_i;
    logic [XLEN-1:0]   rt_data_i;
    logic [XLEN-1:0]   pc_return_addr_i;
    logic              reg_we_i;
    logic [GPR_AW-1:0] reg_waddr_i;
    logic              hi_we_i;
    logic              lo_we_i;
    logic [XLEN-1:0]   hilo_data_i;
    logic              hilo_sel_i;
    logic              mem_hi_we_i;
    logic [XLEN-1:0]   mem_hi_data_i;
    logic              mem_lo_we_i;
    logic [XLEN-1:0]   mem_lo_data_i;
    logic              wb_hi_we_i;
    logic [XLEN-1:0]   wb_hi_data_i;
    logic              wb_lo_we_i;
    logic [XLEN-1:0]   wb_lo_data_i;

    wire [XLEN-1:0]    alu_data_o;
    wire               reg_we_o;
    wire [GPR_AW-1:0]  reg_waddr_o;
    wire               hi_we_o;
    wire               lo_we_o;
    wire [XLEN-1:0]    hi_data_o;
    wire [XLEN-1:0]    lo_data_o;
    wire               overflow_o;
    wire               stall_req_o;

    // expected values, fixed while an op is held
    logic [XLEN-1:0]   exp_result;
    logic              exp_ovf;
    logic [GPR_AW-1:0] exp_waddr;
    logic [63:0]       exp_hilo;

    ex_stage UUT (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .aluop_i          (aluop_i),
        .instr_i          (instr_i),
        .rs_data_i        (rs_data_i),
        .rt_data_i        (rt_data_i),
        .pc_return_addr_i (pc_return_addr_i),
        .reg_we_i         (reg_we_i),
        .reg_waddr_i      (reg_waddr_i),
        .hi_we_i          (hi_we_i),
        .lo_we_i          (lo_we_i),
        .hilo_data_i      (hilo_data_i),
        .hilo_sel_i       (hilo_sel_i),
        .mem_hi_we_i      (mem_hi_we_i),
        .mem_hi_data_i    (mem_hi_data_i),
        .mem_lo_we_i      (mem_lo_we_i),
        .mem_lo_data_i    (mem_lo_data_i),
        .wb_hi_we_i       (wb_hi_we_i),
        .wb_hi_data_i     (wb_hi_data_i),
        .wb_lo_we_i       (wb_lo_we_i),
        .wb_lo_data_i     (wb_lo_data_i),
        .alu_data_o       (alu_data_o),
        .reg_we_o         (reg_we_o),
        .reg_waddr_o      (reg_waddr_o),
        .hi_we_o          (hi_we_o),
        .lo_we_o          (lo_we_o),
        .hi_data_o        (hi_data_o),
        .lo_data_o        (lo_data_o),
        .overflow_o       (overflow_o),
        .stall_req_o      (stall_req_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD/2) clk_i = ~clk_i;
    end

    task automatic check_value(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    // pushes a random word close to the signed limits
    function automatic logic [XLEN-1:0] near_limit(input logic [XLEN-1:0] v);
        return {v[31], {15{~v[31]}}, v[15:0]};
    endfunction

    task automatic drive_random(input aluop_t op);
        logic [31:0] r;
        r = $random(seed);
        aluop_i          = op;
        instr_i          = $random(seed);
        rs_data_i        = $random(seed);
        rt_data_i        = $random(seed);
        pc_return_addr_i = $random(seed);
        hilo_data_i      = $random(seed);
        mem_hi_data_i    = $random(seed);
        mem_lo_data_i    = $random(seed);
        wb_hi_data_i     = $random(seed);
        wb_lo_data_i     = $random(seed);
        reg_we_i         = r[0];
        hi_we_i          = r[1];
        lo_we_i          = r[2];
        hilo_sel_i       = r[3];
        mem_hi_we_i      = r[4];
        mem_lo_we_i      = r[5];
        wb_hi_we_i       = r[6];
        wb_lo_we_i       = r[7];
        reg_waddr_i      = r[12:8];
        if ((op == ALUOP_ADD) || (op == ALUOP_ADDI) || (op == ALUOP_SUB)) begin
            if (r[13]) begin
                rs_data_i = near_limit(rs_data_i);
            end
            if (r[14]) begin
                rt_data_i = near_limit(rt_data_i);
            end
        end
        if (is_divide(op) && (rt_data_i == '0)) begin
            rt_data_i = 32'd1;
        end
    endtask

    task automatic apply_op(input aluop_t op);
        int cycles;
        @(negedge clk_i);
        drive_random(op);
        exp_ovf    = model_ovf(op, instr_i, rs_data_i, rt_data_i);
        exp_result = model_result(op, instr_i, rs_data_i, rt_data_i, pc_return_addr_i,
                                  model_fwd(hilo_sel_i, hilo_data_i,
                                            mem_hi_we_i, mem_hi_data_i,
                                            mem_lo_we_i, mem_lo_data_i,
                                            wb_hi_we_i, wb_hi_data_i,
                                            wb_lo_we_i, wb_lo_data_i));
        exp_waddr  = model_waddr(op, reg_waddr_i, exp_ovf);
        exp_hilo   = model_hilo(op, rs_data_i, rt_data_i);
        #(CLK_PERIOD/4);
        check_value("stall_req_o", XLEN'(stall_req_o), XLEN'(is_divide(op)));
        cycles = 0;
        while (stall_req_o && (cycles < STALL_LIMIT)) begin
            @(posedge clk_i);
            #(CLK_PERIOD/4);
            cycles++;
            // edge taken with the stall high, so a bubble was loaded
            check_value("reg_we_o", XLEN'(reg_we_o), '0);
            check_value("hi_we_o", XLEN'(hi_we_o), '0);
            check_value("lo_we_o", XLEN'(lo_we_o), '0);
            check_value("overflow_o", XLEN'(overflow_o), '0);
        end
        if (stall_req_o) begin
            $display("timeout: stall_req_o still high after %0d cycles on %s",
                     cycles, op.name());
            timed_out = 1'b1;
        end else begin
            @(posedge clk_i);
            #(CLK_PERIOD/4);
            if (!writes_hilo(op)) begin
                check_value("alu_data_o", alu_data_o, exp_result);
            end else begin
                check_value("hi_data_o", hi_data_o, exp_hilo[63:32]);
                check_value("lo_data_o", lo_data_o, exp_hilo[31:0]);
            end
            check_value("reg_we_o", XLEN'(reg_we_o), XLEN'(reg_we_i));
            check_value("reg_waddr_o", XLEN'(reg_waddr_o), XLEN'(exp_waddr));
            check_value("hi_we_o", XLEN'(hi_we_o), XLEN'(hi_we_i));
            check_value("lo_we_o", XLEN'(lo_we_o), XLEN'(lo_we_i));
            check_value("overflow_o", XLEN'(overflow_o), XLEN'(exp_ovf));
        end
    endtask

    initial begin
        seed      = 32'hb3e0;
        errors    = 0;
        checks    = 0;
        timed_out = 1'b0;
        op_table  = '{ALUOP_ADD, ALUOP_ADDI, ALUOP_ADDU, ALUOP_ADDIU, ALUOP_SUB,
                      ALUOP_SUBU, ALUOP_SLT, ALUOP_SLTI, ALUOP_SLTU, ALUOP_SLTIU,
                      ALUOP_AND, ALUOP_ANDI, ALUOP_OR, ALUOP_ORI, ALUOP_XOR,
                      ALUOP_XORI, ALUOP_NOR, ALUOP_LUI, ALUOP_SLL, ALUOP_SLLV,
                      ALUOP_SRL, ALUOP_SRLV, ALUOP_SRA, ALUOP_SRAV, ALUOP_JAL,
                      ALUOP_BGEZAL, ALUOP_BLTZAL, ALUOP_MFHI, ALUOP_MFLO, ALUOP_MTHI,
                      ALUOP_MTLO, ALUOP_MULT, ALUOP_MULTU, ALUOP_DIV, ALUOP_DIVU};

        rst_n_i          = 1'b0;
        aluop_i          = ALUOP_NOP;
        instr_i          = '0;
        rs_data_i        = '0;
        rt_data_i        = '0;
        pc_return_addr_i = '0;
        reg_we_i         = 1'b0;
        reg_waddr_i      = '0;
        hi_we_i          = 1'b0;
        lo_we_i          = 1'b0;
        hilo_data_i      = '0;
        hilo_sel_i       = 1'b0;
        mem_hi_we_i      = 1'b0;
        mem_hi_data_i    = '0;
        mem_lo_we_i      = 1'b0;
        mem_lo_data_i    = '0;
        wb_hi_we_i       = 1'b0;
        wb_hi_data_i     = '0;
        wb_lo_we_i       = 1'b0;
        wb_lo_data_i     = '0;

        repeat (RST_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        // everything cleared while in reset
        check_value("alu_data_o", alu_data_o, '0);
        check_value("reg_we_o", XLEN'(reg_we_o), '0);
        check_value("reg_waddr_o", XLEN'(reg_waddr_o), '0);
        check_value("hi_we_o", XLEN'(hi_we_o), '0);
        check_value("lo_we_o", XLEN'(lo_we_o), '0);
        check_value("hi_data_o", hi_data_o, '0);
        check_value("lo_data_o", lo_data_o, '0);
        check_value("overflow_o", XLEN'(overflow_o), '0);
        check_value("stall_req_o", XLEN'(stall_req_o), '0);
        rst_n_i = 1'b1;

        for (run = 0; (run < NUM_RUNS) && !timed_out; run++) begin
            idx = $unsigned($random(seed)) % NUM_OPS;
            apply_op(op_table[idx]);
        end

        $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timed_out);
        if ((errors == 0) && !timed_out) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+.
ex_pkg.sv
ex_alu.sv
ex_hilo_unit.sv
ex_divider.sv
ex_ctrl.sv
ex_stage.sv
tb_ex_stage.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_ex_stage
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
FAIL_MSG  ?= Simulation failed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)
